// ==== src.f ====
hw/pad_pkg.sv
hw/pad_cell.sv
hw/pad_frame.sv
hw/boot_strap_ctrl.sv
hw/jtag_tap.sv
hw/chip_io_top.sv
bench/jtag_tap_sva.sv
bench/chip_io_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds with Verilator and passes only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module chip_io_tb -f src.f -Mdir obj_dir \
    && ./obj_dir/Vchip_io_tb | tee /dev/stderr | grep -q "^TEST OK$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== bench/chip_io_tb.sv ====
// Drives both JTAG ports through the pads on one shared 4 ns clock; straps come from $urandom
`timescale 1ns/100ps

module chip_io_tb
    import pad_pkg::*;
();

    localparam int NUM_ROWS    = 13;
    localparam int KIND_FIXED  = 0;
    localparam int KIND_BYPASS = 1;
    localparam int KIND_STATUS = 2;
    localparam int RST_TIMEOUT = 20;

    logic clk;
    logic drv_reset_n;
    logic drv_bypass;
    logic drv_bootmode;
    logic bootmode_float;
    logic drv_tms;
    logic drv_tdi;
    logic drv_trst;
    logic drv_tms_ot;
    logic drv_tdi_ot;
    logic drv_trst_ot;

    wire pad_xtal_in;
    wire pad_reset_n;
    wire pad_bypass;
    wire pad_bootmode;
    wire pad_jtag_tck;
    wire pad_jtag_tms;
    wire pad_jtag_tdi;
    wire pad_jtag_trst;
    wire pad_jtag_tdo;
    wire pad_jtag_ot_tck;
    wire pad_jtag_ot_tms;
    wire pad_jtag_ot_tdi;
    wire pad_jtag_ot_trst;
    wire pad_jtag_ot_tdo;

    // Reference model of the captured straps
    logic exp_bootmode;
    logic exp_bypass;

    int errors;
    int checks;

    // One scan table row per DR scan
    logic        row_tap   [NUM_ROWS];
    logic        row_reset [NUM_ROWS];
    logic        row_load  [NUM_ROWS];
    logic [3:0]  row_instr [NUM_ROWS];
    int          row_len   [NUM_ROWS];
    int          row_kind  [NUM_ROWS];
    logic [31:0] row_value [NUM_ROWS];

    assign pad_xtal_in      = clk;
    assign pad_jtag_tck     = clk;
    assign pad_jtag_ot_tck  = clk;
    assign pad_reset_n      = drv_reset_n;
    assign pad_bypass       = drv_bypass;
    assign pad_bootmode     = bootmode_float ? 1'bz : drv_bootmode;
    assign pad_jtag_tms     = drv_tms;
    assign pad_jtag_tdi     = drv_tdi;
    assign pad_jtag_trst    = drv_trst;
    assign pad_jtag_ot_tms  = drv_tms_ot;
    assign pad_jtag_ot_tdi  = drv_tdi_ot;
    assign pad_jtag_ot_trst = drv_trst_ot;

    chip_io_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_row(input int idx, input logic tap, input logic rst, input logic load,
                           input logic [3:0] instr, input int len, input int kind,
                           input logic [31:0] value);
        row_tap[idx]   = tap;
        row_reset[idx] = rst;
        row_load[idx]  = load;
        row_instr[idx] = instr;
        row_len[idx]   = len;
        row_kind[idx]  = kind;
        row_value[idx] = value;
    endtask

    // One TCK cycle on the selected port while the idle port keeps TMS low
    task automatic tck_step(input logic tap, input logic tms, input logic tdi);
        @(negedge clk);
        if (tap) begin
            drv_tms_ot = tms;
            drv_tdi_ot = tdi;
        end else begin
            drv_tms = tms;
            drv_tdi = tdi;
        end
        @(posedge clk);
    endtask

    task automatic tms_reset(input logic tap);
        repeat (5) tck_step(tap, 1'b1, 1'b0);
        tck_step(tap, 1'b0, 1'b0);
    endtask

    // Shifts LSB first from Shift state, leaves through Exit1 and Update into Run-Test/Idle
    task automatic shift_bits(input logic tap, input int len, input logic [31:0] din,
                              output logic [31:0] dout);
        dout = '0;
        for (int i = 0; i < len; i++) begin
            tck_step(tap, (i == len - 1), din[i]);
            dout[i] = tap ? pad_jtag_ot_tdo : pad_jtag_tdo;
        end
        tck_step(tap, 1'b1, 1'b0);
        tck_step(tap, 1'b0, 1'b0);
    endtask

    task automatic load_ir(input logic tap, input logic [3:0] instr);
        logic [31:0] unused;
        tck_step(tap, 1'b1, 1'b0);
        tck_step(tap, 1'b1, 1'b0);
        tck_step(tap, 1'b0, 1'b0);
        tck_step(tap, 1'b0, 1'b0);
        shift_bits(tap, IR_WIDTH, {28'h0, instr}, unused);
    endtask

    task automatic scan_dr(input logic tap, input int len, input logic [31:0] din,
                           output logic [31:0] dout);
        tck_step(tap, 1'b1, 1'b0);
        tck_step(tap, 1'b0, 1'b0);
        tck_step(tap, 1'b0, 1'b0);
        shift_bits(tap, len, din, dout);
    endtask

    // Expected STATUS from the captured straps and the TAP index, upper bits zero
    function automatic logic [31:0] status_expect(input logic tap);
        return {24'h0, 4'h0, tap, 1'b1, exp_bypass, exp_bootmode};
    endfunction

    task automatic run_row(input int r);
        logic [31:0] din;
        logic [31:0] dout;
        logic [31:0] expv;
        din = $urandom;
        if (row_reset[r]) tms_reset(row_tap[r]);
        if (row_load[r]) load_ir(row_tap[r], row_instr[r]);
        scan_dr(row_tap[r], row_len[r], din, dout);
        case (row_kind[r])
            KIND_BYPASS: expv = {din[30:0], 1'b0};
            KIND_STATUS: expv = status_expect(row_tap[r]);
            default:     expv = row_value[r];
        endcase
        for (int i = 0; i < row_len[r]; i++) begin
            checks++;
            assert (dout[i] === expv[i]) else begin
                errors++;
                $display("FAILED at %0t ns: row %0d tap %0d bit %0d read %b expected %b",
                         $time, r, row_tap[r], i, dout[i], expv[i]);
            end
        end
    endtask

    task automatic run_rows(input int lo, input int hi);
        for (int r = lo; r <= hi; r++) run_row(r);
    endtask

    task automatic wait_rst_release();
        int n;
        n = 0;
        while (uut.rst_sync_n !== 1'b1 && n < RST_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (uut.rst_sync_n !== 1'b1) begin
            errors++;
            $display("Timeout: synchronized reset was not released after pad reset");
        end
    endtask

    // Pad reset that applies new straps and can leave the bootmode pad floating
    task automatic pad_reset(input logic bootmode, input logic bypass, input logic float_bm);
        @(negedge clk);
        bootmode_float = float_bm;
        drv_bootmode   = bootmode;
        drv_bypass     = bypass;
        drv_reset_n    = 1'b0;
        repeat (2) @(negedge clk);
        drv_reset_n    = 1'b1;
        // Floating bootmode pad is pulled down
        exp_bootmode   = float_bm ? 1'b0 : bootmode;
        exp_bypass     = bypass;
        wait_rst_release();
    endtask

    initial begin
        logic bm;
        logic bp;
        errors      = 0;
        checks      = 0;
        void'($urandom(32'hdabf));
        drv_reset_n = 1'b0;
        drv_trst    = 1'b0;
        drv_trst_ot = 1'b0;
        drv_tms     = 1'b0;
        drv_tdi     = 1'b0;
        drv_tms_ot  = 1'b0;
        drv_tdi_ot  = 1'b0;
        bm          = $urandom;
        bp          = $urandom;
        bootmode_float = 1'b0;
        drv_bootmode   = bm;
        drv_bypass     = bp;

        add_row(0,  1'b0, 1'b1, 1'b0, INSTR_IDCODE, 32, KIND_FIXED,  IDCODE_MAIN);
        add_row(1,  1'b1, 1'b1, 1'b0, INSTR_IDCODE, 32, KIND_FIXED,  IDCODE_SECURE);
        add_row(2,  1'b0, 1'b1, 1'b1, INSTR_BYPASS, 16, KIND_BYPASS, '0);
        add_row(3,  1'b1, 1'b1, 1'b1, 4'h7,         16, KIND_BYPASS, '0);
        add_row(4,  1'b0, 1'b1, 1'b1, INSTR_STATUS, 8,  KIND_STATUS, '0);
        add_row(5,  1'b1, 1'b1, 1'b1, INSTR_STATUS, 8,  KIND_STATUS, '0);
        // The untouched TAP is rescanned later without reset or IR load
        add_row(6,  1'b0, 1'b1, 1'b1, INSTR_STATUS, 8,  KIND_STATUS, '0);
        add_row(7,  1'b1, 1'b1, 1'b1, INSTR_BYPASS, 12, KIND_BYPASS, '0);
        add_row(8,  1'b0, 1'b0, 1'b0, INSTR_STATUS, 8,  KIND_STATUS, '0);
        add_row(9,  1'b1, 1'b0, 1'b0, INSTR_BYPASS, 12, KIND_BYPASS, '0);
        add_row(10, 1'b0, 1'b1, 1'b0, INSTR_IDCODE, 32, KIND_FIXED,  IDCODE_MAIN);
        add_row(11, 1'b1, 1'b1, 1'b1, INSTR_STATUS, 8,  KIND_STATUS, '0);
        add_row(12, 1'b0, 1'b0, 1'b0, INSTR_IDCODE, 32, KIND_FIXED,  IDCODE_MAIN);

        repeat (2) @(negedge clk);
        drv_reset_n  = 1'b1;
        drv_trst     = 1'b1;
        drv_trst_ot  = 1'b1;
        exp_bootmode = bm;
        exp_bypass   = bp;
        wait_rst_release();
        run_rows(0, NUM_ROWS - 1);

        // Straps flipped after release must not reach STATUS
        @(negedge clk);
        drv_bootmode = ~bm;
        drv_bypass   = ~bp;
        run_rows(4, 5);
        pad_reset(~bm, ~bp, 1'b0);
        run_rows(4, 5);

        // Floating bootmode pad
        pad_reset(1'b1, $urandom, 1'b1);
        run_rows(4, 5);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/jtag_tap_sva.sv ====
// Checks sample on TCK rising edges and are disabled while TRST is low
`timescale 1ns/100ps

module jtag_tap_sva
    import pad_pkg::*;
(
    input logic                tck_i,
    input logic                arst_n_i,
    input logic                tms_i,
    input logic                tdo_o,
    input logic [3:0]          state_q,
    input logic [IR_WIDTH-1:0] ir_q
);

    localparam logic [3:0] ST_RESET    = 4'hF;
    localparam logic [3:0] ST_SHIFT_DR = 4'h2;
    localparam logic [3:0] ST_SHIFT_IR = 4'hA;

    // TDO idles low unless a register is being shifted
    assert property (@(posedge tck_i) disable iff (!arst_n_i)
        !(state_q == ST_SHIFT_DR || state_q == ST_SHIFT_IR) |-> tdo_o == 1'b0)
        else $error("TDO not low outside Shift states");

    assert property (@(posedge tck_i) disable iff (!arst_n_i)
        tms_i ##1 tms_i ##1 tms_i ##1 tms_i ##1 tms_i |=> state_q == ST_RESET)
        else $error("Five TMS high cycles did not reach Test-Logic-Reset");

    assert property (@(posedge tck_i) disable iff (!arst_n_i)
        state_q == ST_RESET |=> ir_q == INSTR_IDCODE)
        else $error("Instruction is not IDCODE after Test-Logic-Reset");

endmodule

bind jtag_tap jtag_tap_sva u_tap_sva (
    .tck_i    (tck_i),
    .arst_n_i (arst_n_i),
    .tms_i    (tms_i),
    .tdo_o    (tdo_o),
    .state_q  (state_q),
    .ir_q     (ir_q)
);

// ==== hw/chip_io_top.sv ====
// Top of the I/O ring; JTAG paths are combinational through the pads, TAP resets come from TRST only
`timescale 1ns/100ps

module chip_io_top
    import pad_pkg::*;
(
    inout wire pad_xtal_in,
    inout wire pad_reset_n,
    inout wire pad_bypass,
    inout wire pad_bootmode,

    inout wire pad_jtag_tck,
    inout wire pad_jtag_tms,
    inout wire pad_jtag_tdi,
    inout wire pad_jtag_trst,
    inout wire pad_jtag_tdo,

    inout wire pad_jtag_ot_tck,
    inout wire pad_jtag_ot_tms,
    inout wire pad_jtag_ot_tdi,
    inout wire pad_jtag_ot_trst,
    inout wire pad_jtag_ot_tdo
);

    logic ref_clk;
    logic rstn;
    logic bypass_pin;
    logic bootmode_pin;

    logic jtag_tck;
    logic jtag_tms;
    logic jtag_tdi;
    logic jtag_trst;
    logic jtag_tdo;

    logic jtag_tck_ot;
    logic jtag_tms_ot;
    logic jtag_tdi_ot;
    logic jtag_trst_ot;
    logic jtag_tdo_ot;

    logic rst_sync_n;
    logic bootmode;
    logic bypass;

    logic [STATUS_WIDTH-1:0] status;

    pad_frame i_pad_frame (
        .ref_clk_o        (ref_clk),
        .rstn_o           (rstn),
        .bypass_o         (bypass_pin),
        .bootmode_o       (bootmode_pin),
        .jtag_tck_o       (jtag_tck),
        .jtag_tms_o       (jtag_tms),
        .jtag_tdi_o       (jtag_tdi),
        .jtag_trst_o      (jtag_trst),
        .jtag_tdo_i       (jtag_tdo),
        .jtag_tck_ot_o    (jtag_tck_ot),
        .jtag_tms_ot_o    (jtag_tms_ot),
        .jtag_tdi_ot_o    (jtag_tdi_ot),
        .jtag_trst_ot_o   (jtag_trst_ot),
        .jtag_tdo_ot_i    (jtag_tdo_ot),
        .pad_xtal_in      (pad_xtal_in),
        .pad_reset_n      (pad_reset_n),
        .pad_bypass       (pad_bypass),
        .pad_bootmode     (pad_bootmode),
        .pad_jtag_tck     (pad_jtag_tck),
        .pad_jtag_tms     (pad_jtag_tms),
        .pad_jtag_tdi     (pad_jtag_tdi),
        .pad_jtag_trst    (pad_jtag_trst),
        .pad_jtag_tdo     (pad_jtag_tdo),
        .pad_jtag_ot_tck  (pad_jtag_ot_tck),
        .pad_jtag_ot_tms  (pad_jtag_ot_tms),
        .pad_jtag_ot_tdi  (pad_jtag_ot_tdi),
        .pad_jtag_ot_trst (pad_jtag_ot_trst),
        .pad_jtag_ot_tdo  (pad_jtag_ot_tdo)
    );

    boot_strap_ctrl i_boot_strap_ctrl (
        .ref_clk_i        (ref_clk),
        .arst_n_i         (rstn),
        .bootmode_strap_i (bootmode_pin),
        .bypass_strap_i   (bypass_pin),
        .rst_sync_n_o     (rst_sync_n),
        .bootmode_o       (bootmode),
        .bypass_o         (bypass)
    );

    // Bit 3 is left at 0 here, each TAP inserts its own index
    assign status = {4'b0000, 1'b0, rst_sync_n, bypass, bootmode};

    jtag_tap #(
        .IDCODE_VAL (IDCODE_MAIN),
        .TAP_INDEX  (1'b0)
    ) u_tap_main (
        .tck_i    (jtag_tck),
        .arst_n_i (jtag_trst),
        .tms_i    (jtag_tms),
        .tdi_i    (jtag_tdi),
        .status_i (status),
        .tdo_o    (jtag_tdo)
    );

    jtag_tap #(
        .IDCODE_VAL (IDCODE_SECURE),
        .TAP_INDEX  (1'b1)
    ) u_tap_secure (
        .tck_i    (jtag_tck_ot),
        .arst_n_i (jtag_trst_ot),
        .tms_i    (jtag_tms_ot),
        .tdi_i    (jtag_tdi_ot),
        .status_i (status),
        .tdo_o    (jtag_tdo_ot)
    );

endmodule

// ==== hw/jtag_tap.sv ====
// IEEE 1149.1 style TAP with IDCODE, BYPASS and STATUS only; unknown instructions act as BYPASS
`timescale 1ns/100ps

module jtag_tap
    import pad_pkg::*;
#(
    parameter logic [31:0] IDCODE_VAL = IDCODE_MAIN,
    parameter bit          TAP_INDEX  = 1'b0
) (
    input  logic                    tck_i,
    input  logic                    arst_n_i,
    input  logic                    tms_i,
    input  logic                    tdi_i,
    input  logic [STATUS_WIDTH-1:0] status_i,
    output logic                    tdo_o
);

    // Encoding follows the usual 1149.1 state numbering
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'hF,
        RUN_TEST_IDLE    = 4'hC,
        SELECT_DR_SCAN   = 4'h7,
        CAPTURE_DR       = 4'h6,
        SHIFT_DR         = 4'h2,
        EXIT1_DR         = 4'h1,
        PAUSE_DR         = 4'h3,
        EXIT2_DR         = 4'h0,
        UPDATE_DR        = 4'h5,
        SELECT_IR_SCAN   = 4'h4,
        CAPTURE_IR       = 4'hE,
        SHIFT_IR         = 4'hA,
        EXIT1_IR         = 4'h9,
        PAUSE_IR         = 4'hB,
        EXIT2_IR         = 4'h8,
        UPDATE_IR        = 4'hD
    } tap_state_e;

    tap_state_e state_q;
    tap_state_e state_d;

    logic [IR_WIDTH-1:0]     ir_shift_q;
    logic [IR_WIDTH-1:0]     ir_q;
    logic [31:0]             idcode_q;
    logic                    bypass_q;
    logic [STATUS_WIDTH-1:0] status_q;
    logic [STATUS_WIDTH-1:0] status_cap;
    logic                    sel_idcode;
    logic                    sel_status;
    logic                    dr_bit;

    // Next state
    always_comb begin
        case (state_q)
            TEST_LOGIC_RESET: state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_d = tms_i ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_d = TEST_LOGIC_RESET;
        endcase
    end

    // State and active instruction
    always_ff @(posedge tck_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TEST_LOGIC_RESET;
            ir_q    <= INSTR_IDCODE;
        end else begin
            state_q <= state_d;
            if (state_q == TEST_LOGIC_RESET) begin
                ir_q <= INSTR_IDCODE;
            end else if (state_q == UPDATE_IR) begin
                ir_q <= ir_shift_q;
            end
        end
    end

    // Anything not decoded here falls through to BYPASS
    assign sel_idcode = (ir_q == INSTR_IDCODE);
    assign sel_status = (ir_q == INSTR_STATUS);

    // Own index replaces bit 3 of the incoming level
    always_comb begin
        status_cap                   = status_i;
        status_cap[STATUS_TAP_INDEX] = TAP_INDEX;
    end

    // Shift paths, LSB leaves first and TDI enters at the top
    always_ff @(posedge tck_i) begin
        if (state_q == CAPTURE_IR) begin
            ir_shift_q <= {{(IR_WIDTH-2){1'b0}}, 2'b01};
        end else if (state_q == SHIFT_IR) begin
            ir_shift_q <= {tdi_i, ir_shift_q[IR_WIDTH-1:1]};
        end

        if (state_q == CAPTURE_DR) begin
            if (sel_idcode) begin
                idcode_q <= IDCODE_VAL;
            end else if (sel_status) begin
                status_q <= status_cap;
            end else begin
                bypass_q <= 1'b0;
            end
        end else if (state_q == SHIFT_DR) begin
            if (sel_idcode) begin
                idcode_q <= {tdi_i, idcode_q[31:1]};
            end else if (sel_status) begin
                status_q <= {tdi_i, status_q[STATUS_WIDTH-1:1]};
            end else begin
                bypass_q <= tdi_i;
            end
        end
    end

    always_comb begin
        if (sel_idcode) begin
            dr_bit = idcode_q[0];
        end else if (sel_status) begin
            dr_bit = status_q[0];
        end else begin
            dr_bit = bypass_q;
        end
    end

    // TDO is launched on the falling edge and idles low
    always_ff @(negedge tck_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tdo_o <= 1'b0;
        end else if (state_q == SHIFT_IR) begin
            tdo_o <= ir_shift_q[0];
        end else if (state_q == SHIFT_DR) begin
            tdo_o <= dr_bit;
        end else begin
            tdo_o <= 1'b0;
        end
    end

endmodule

// ==== hw/boot_strap_ctrl.sv ====
// Straps must be stable around reset release; they are sampled once and then ignored until the next reset
`timescale 1ns/100ps

module boot_strap_ctrl (
    input  logic ref_clk_i,
    input  logic arst_n_i,
    input  logic bootmode_strap_i,
    input  logic bypass_strap_i,
    output logic rst_sync_n_o,
    output logic bootmode_o,
    output logic bypass_o
);

    logic [1:0] sync_q;
    logic       release_edge;
    logic       bootmode_q;
    logic       bypass_q;

    // Asserts asynchronously, releases on the second ref_clk edge
    always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // True only in the cycle before the synchronized reset goes high
    assign release_edge = sync_q[0] & ~sync_q[1];

    // Strap capture on the very edge that releases the core reset
    always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bootmode_q <= 1'b0;
            bypass_q   <= 1'b0;
        end else if (release_edge) begin
            bootmode_q <= bootmode_strap_i;
            bypass_q   <= bypass_strap_i;
        end
    end

    assign rst_sync_n_o = sync_q[1];
    assign bootmode_o   = bootmode_q;
    assign bypass_o     = bypass_q;

endmodule

// ==== hw/pad_frame.sv ====
// Pad ring of the chip; directions and pulls are fixed per pad, TDO pads are always driven
`timescale 1ns/100ps

module pad_frame
    import pad_pkg::*;
(
    output logic ref_clk_o,
    output logic rstn_o,
    output logic bypass_o,
    output logic bootmode_o,

    // Main debug JTAG port
    output logic jtag_tck_o,
    output logic jtag_tms_o,
    output logic jtag_tdi_o,
    output logic jtag_trst_o,
    input  logic jtag_tdo_i,

    // Secure core JTAG port
    output logic jtag_tck_ot_o,
    output logic jtag_tms_ot_o,
    output logic jtag_tdi_ot_o,
    output logic jtag_trst_ot_o,
    input  logic jtag_tdo_ot_i,

    inout  wire  pad_xtal_in,
    inout  wire  pad_reset_n,
    inout  wire  pad_bypass,
    inout  wire  pad_bootmode,

    inout  wire  pad_jtag_tck,
    inout  wire  pad_jtag_tms,
    inout  wire  pad_jtag_tdi,
    inout  wire  pad_jtag_trst,
    inout  wire  pad_jtag_tdo,

    inout  wire  pad_jtag_ot_tck,
    inout  wire  pad_jtag_ot_tms,
    inout  wire  pad_jtag_ot_tdi,
    inout  wire  pad_jtag_ot_trst,
    inout  wire  pad_jtag_ot_tdo
);

    // Clock, reset and straps
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_ref_clk (
        .oen_i(1'b1), .i_i(1'b0), .o_o(ref_clk_o), .pad_io(pad_xtal_in));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_reset_n (
        .oen_i(1'b1), .i_i(1'b0), .o_o(rstn_o), .pad_io(pad_reset_n));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_bypass (
        .oen_i(1'b1), .i_i(1'b0), .o_o(bypass_o), .pad_io(pad_bypass));
    // Floating bootmode pad reads as 0
    pad_cell #(.PULL_SEL(PULL_DOWN)) padinst_bootmode (
        .oen_i(1'b1), .i_i(1'b0), .o_o(bootmode_o), .pad_io(pad_bootmode));

    // Main JTAG port, an open TRST keeps the TAP out of reset
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_tck (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_tck_o), .pad_io(pad_jtag_tck));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_tms (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_tms_o), .pad_io(pad_jtag_tms));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_tdi (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_tdi_o), .pad_io(pad_jtag_tdi));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_trst (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_trst_o), .pad_io(pad_jtag_trst));
    pad_cell #(.PULL_SEL(PULL_DOWN)) padinst_jtag_tdo (
        .oen_i(1'b0), .i_i(jtag_tdo_i), .o_o(), .pad_io(pad_jtag_tdo));

    // Secure core JTAG port
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_ot_tck (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_tck_ot_o), .pad_io(pad_jtag_ot_tck));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_ot_tms (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_tms_ot_o), .pad_io(pad_jtag_ot_tms));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_ot_tdi (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_tdi_ot_o), .pad_io(pad_jtag_ot_tdi));
    pad_cell #(.PULL_SEL(PULL_UP)) padinst_jtag_ot_trst (
        .oen_i(1'b1), .i_i(1'b0), .o_o(jtag_trst_ot_o), .pad_io(pad_jtag_ot_trst));
    pad_cell #(.PULL_SEL(PULL_DOWN)) padinst_jtag_ot_tdo (
        .oen_i(1'b0), .i_i(jtag_tdo_ot_i), .o_o(), .pad_io(pad_jtag_ot_tdo));

endmodule

// ==== hw/pad_cell.sv ====
// Behavioral pad only: a strong driver plus a weak pull keeper, no drive strength or slew control
`timescale 1ns/100ps

module pad_cell
    import pad_pkg::*;
#(
    parameter bit PULL_SEL = PULL_UP
) (
    input  logic oen_i,
    input  logic i_i,
    output logic o_o,
    inout  wire  pad_io
);

    // Output enable is active low, a high oen_i leaves the pad to the outside world
    assign pad_io = oen_i ? 1'bz : i_i;

    // Weak keeper, overridden by any strong driver on the pad
    generate
        if (PULL_SEL == PULL_UP) begin : g_pull_up
            pullup (pad_io);
        end else begin : g_pull_down
            pulldown (pad_io);
        end
    endgenerate

    // Receiver always sees the pad, also while driving
    assign o_o = pad_io;

endmodule

// ==== hw/pad_pkg.sv ====
// Shared constants for the pad ring and the JTAG TAPs; the STATUS layout assumes an 8 bit register
package pad_pkg;

    // TAP instruction register
    localparam int unsigned IR_WIDTH = 4;

    localparam logic [IR_WIDTH-1:0] INSTR_IDCODE = 4'h1;
    localparam logic [IR_WIDTH-1:0] INSTR_STATUS = 4'h2;
    // All ones, any other unknown code falls back to BYPASS as well
    localparam logic [IR_WIDTH-1:0] INSTR_BYPASS = 4'hF;

    // Identification codes, bit 0 is always set
    localparam logic [31:0] IDCODE_MAIN   = 32'h1001_00DB;
    localparam logic [31:0] IDCODE_SECURE = 32'h2002_00DB;

    // STATUS register
    // bit 0 bootmode, bit 1 bypass, bit 2 reset released, bit 3 TAP index
    // Bits 7..4 read as zero
    localparam int unsigned STATUS_WIDTH     = 8;
    localparam int unsigned STATUS_BOOTMODE  = 0;
    localparam int unsigned STATUS_BYPASS    = 1;
    localparam int unsigned STATUS_RST_DONE  = 2;
    localparam int unsigned STATUS_TAP_INDEX = 3;

    // Keeper selection for pad_cell
    localparam bit PULL_UP   = 1'b1;
    localparam bit PULL_DOWN = 1'b0;

endpackage
